//--- design/bank_array.sv
module bank_array (
  input logic      clk,
  bank_port_if.mem bus
);

  import mem_cfg_pkg::*;

  // first read stage sits inside each bank.
  data_t bank_q [NUM_BANKS];
  bank_t sel_q;

  // remaining read stages after the bank select.
  data_t rd_pipe [RD_LAT-1];

  // **************************************
  // single-port banks
  // **************************************

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    data_t ram [NUM_ROWS];
    logic  bank_wr;
    logic  bank_rd;

    assign bank_wr = bus.write && (int'(bus.wr_bank) == b);
    assign bank_rd = bus.read && (int'(bus.rd_bank) == b);

    always_ff @(posedge clk) begin
      if (bank_wr) begin
        ram[bus.wr_row] <= bus.wr_data;
      end
      if (bank_rd) begin
        bank_q[b] <= ram[bus.rd_row];
      end
    end
  end

  // **************************************
  // read return
  // **************************************

  always_ff @(posedge clk) begin
    if (bus.read) begin
      sel_q <= bus.rd_bank;
    end
  end

  always_ff @(posedge clk) begin
    rd_pipe[0] <= bank_q[sel_q];
    for (int i = 1; i < RD_LAT - 1; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign bus.rd_data = rd_pipe[RD_LAT-2];

  // a bank serves one access per edge; the controller must steer
  // every colliding write into the cache.
  a_one_access_per_bank: assert property (
    @(posedge bus.clk) (bus.write && bus.read) |-> (bus.wr_bank != bus.rd_bank)
  ) else $error("bank %0d written and read in one cycle", bus.rd_bank);

endmodule

//--- design/bank_mux.sv
module bank_mux (
  input  logic                clk,
  // controller side, requests.
  input  logic                pwrite,
  input  mem_cfg_pkg::bank_t  pwr_bank,
  input  mem_cfg_pkg::row_t   pwr_row,
  input  mem_cfg_pkg::data_t  pdin,
  input  logic                pread,
  input  mem_cfg_pkg::bank_t  prd_bank,
  input  mem_cfg_pkg::row_t   prd_row,
  input  logic                swrite,
  input  mem_cfg_pkg::row_t   swr_row,
  input  mem_ops_pkg::tag_t   stag,
  input  mem_cfg_pkg::data_t  sdin,
  input  logic                sread1,
  input  mem_cfg_pkg::row_t   srd_row1,
  input  logic                sread2,
  input  mem_cfg_pkg::row_t   srd_row2,
  // controller side, returns.
  output mem_cfg_pkg::data_t  pdout,
  output mem_ops_pkg::tag_t   stag1,
  output mem_cfg_pkg::data_t  sdout1,
  output mem_ops_pkg::tag_t   stag2,
  output mem_cfg_pkg::data_t  sdout2,
  // memory side.
  bank_port_if.mux            bank,
  cache_port_if.mux           cache
);

  import mem_cfg_pkg::*;
  import mem_ops_pkg::*;

  logic wr_in_range;
  logic rd_in_range;

  assign wr_in_range = int'(pwr_bank) < NUM_BANKS;
  assign rd_in_range = int'(prd_bank) < NUM_BANKS;

  // **************************************
  // banked memory
  // **************************************

  assign bank.write   = pwrite && wr_in_range;
  assign bank.wr_bank = pwr_bank;
  assign bank.wr_row  = pwr_row;
  assign bank.wr_data = pdin;

  assign bank.read    = pread && rd_in_range;
  assign bank.rd_bank = prd_bank;
  assign bank.rd_row  = prd_row;
  assign pdout        = bank.rd_data;

  // **************************************
  // cache, tag packed above the data
  // **************************************

  assign cache.write   = swrite;
  assign cache.wr_row  = swr_row;
  assign cache.wr_word = {stag, sdin};

  assign cache.read1   = sread1;
  assign cache.rd_row1 = srd_row1;
  assign cache.read2   = sread2;
  assign cache.rd_row2 = srd_row2;

  assign stag1  = cache.rd_word1[CWORD_W-1 -: TAG_W];
  assign sdout1 = cache.rd_word1[DATA_W-1:0];
  assign stag2  = cache.rd_word2[CWORD_W-1 -: TAG_W];
  assign sdout2 = cache.rd_word2[DATA_W-1:0];

  a_bank_in_range: assert property (
    @(posedge clk) (pwrite || pread) |-> ((!pwrite || wr_in_range) && (!pread || rd_in_range))
  ) else $error("bank strobe with out-of-range bank index");

endmodule

//--- design/bank_port_if.sv
interface bank_port_if (
  input logic clk
);

  import mem_cfg_pkg::*;

  logic  write;
  bank_t wr_bank;
  row_t  wr_row;
  data_t wr_data;
  logic  read;
  bank_t rd_bank;
  row_t  rd_row;
  data_t rd_data;

  modport mux (
    output write, wr_bank, wr_row, wr_data,
    output read, rd_bank, rd_row,
    input  rd_data
  );

  modport mem (
    input  clk,
    input  write, wr_bank, wr_row, wr_data,
    input  read, rd_bank, rd_row,
    output rd_data
  );

endinterface

//--- design/cache_port_if.sv
interface cache_port_if (
  input logic clk
);

  import mem_cfg_pkg::*;
  import mem_ops_pkg::*;

  // one write port.
  logic        write;
  row_t        wr_row;
  cache_word_t wr_word;

  // read port 1 serves the user read, port 2 the write lookup.
  logic        read1;
  row_t        rd_row1;
  cache_word_t rd_word1;
  logic        read2;
  row_t        rd_row2;
  cache_word_t rd_word2;

  modport mux (
    output write, wr_row, wr_word,
    output read1, rd_row1, read2, rd_row2,
    input  rd_word1, rd_word2
  );

  modport mem (
    input  clk,
    input  write, wr_row, wr_word,
    input  read1, rd_row1, read2, rd_row2,
    output rd_word1, rd_word2
  );

endinterface

//--- design/cache_sram.sv
module cache_sram (
  input logic       clk,
  input logic       rst_n,
  cache_port_if.mem bus
);

  import mem_cfg_pkg::*;
  import mem_ops_pkg::*;

  cache_word_t         mem [NUM_ROWS];
  logic [NUM_ROWS-1:0] row_vld;

  cache_word_t       rd_pipe1 [RD_LAT];
  cache_word_t       rd_pipe2 [RD_LAT];
  logic [RD_LAT-1:0] vld_pipe1;
  logic [RD_LAT-1:0] vld_pipe2;

  always_ff @(posedge clk) begin
    if (bus.write) begin
      mem[bus.wr_row] <= bus.wr_word;
    end
    if (bus.read1) begin
      rd_pipe1[0] <= mem[bus.rd_row1];
    end
    if (bus.read2) begin
      rd_pipe2[0] <= mem[bus.rd_row2];
    end
    for (int i = 1; i < RD_LAT; i++) begin
      rd_pipe1[i] <= rd_pipe1[i-1];
      rd_pipe2[i] <= rd_pipe2[i-1];
    end
  end

  // rows never written since reset read back with an invalid tag.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_vld   <= '0;
      vld_pipe1 <= '0;
      vld_pipe2 <= '0;
    end else begin
      if (bus.write) begin
        row_vld[bus.wr_row] <= 1'b1;
      end
      if (bus.read1) begin
        vld_pipe1[0] <= row_vld[bus.rd_row1];
      end
      if (bus.read2) begin
        vld_pipe2[0] <= row_vld[bus.rd_row2];
      end
      vld_pipe1[RD_LAT-1:1] <= vld_pipe1[RD_LAT-2:0];
      vld_pipe2[RD_LAT-1:1] <= vld_pipe2[RD_LAT-2:0];
    end
  end

  assign bus.rd_word1 = {rd_pipe1[RD_LAT-1][CWORD_W-1] & vld_pipe1[RD_LAT-1],
                         rd_pipe1[RD_LAT-1][CWORD_W-2:0]};
  assign bus.rd_word2 = {rd_pipe2[RD_LAT-1][CWORD_W-1] & vld_pipe2[RD_LAT-1],
                         rd_pipe2[RD_LAT-1][CWORD_W-2:0]};

  a_rd_row1_known: assert property (
    @(posedge bus.clk) disable iff (!rst_n) bus.read1 |-> !$isunknown(bus.rd_row1)
  ) else $error("cache read1 with unknown row");

  a_rd_row2_known: assert property (
    @(posedge bus.clk) disable iff (!rst_n) bus.read2 |-> !$isunknown(bus.rd_row2)
  ) else $error("cache read2 with unknown row");

endmodule

//--- design/conflict_ctrl.sv
module conflict_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                write,
  input  logic                read,
  input  mem_cfg_pkg::bank_t  wr_bank,
  input  mem_cfg_pkg::bank_t  rd_bank,
  input  mem_cfg_pkg::row_t   wr_row,
  input  mem_cfg_pkg::row_t   rd_row,
  input  mem_cfg_pkg::data_t  wr_data,
  output mem_cfg_pkg::data_t  rd_data,
  output logic                pwrite,
  output mem_cfg_pkg::bank_t  pwr_bank,
  output mem_cfg_pkg::row_t   pwr_row,
  output mem_cfg_pkg::data_t  pdin,
  output logic                pread,
  output mem_cfg_pkg::bank_t  prd_bank,
  output mem_cfg_pkg::row_t   prd_row,
  output logic                swrite,
  output mem_cfg_pkg::row_t   swr_row,
  output mem_ops_pkg::tag_t   stag,
  output mem_cfg_pkg::data_t  sdin,
  output logic                sread1,
  output mem_cfg_pkg::row_t   srd_row1,
  output logic                sread2,
  output mem_cfg_pkg::row_t   srd_row2,
  input  mem_cfg_pkg::data_t  pdout,
  input  mem_ops_pkg::tag_t   stag1,
  input  mem_cfg_pkg::data_t  sdout1,
  input  mem_ops_pkg::tag_t   stag2,
  input  mem_cfg_pkg::data_t  sdout2
);

  import mem_cfg_pkg::*;
  import mem_ops_pkg::*;

  // write stages; fwd marks a cache row changed since the lookup.
  logic        s1_vld, s2_vld;
  bank_t       s1_bank, s2_bank;
  row_t        s1_row, s2_row;
  data_t       s1_data, s2_data;
  logic        s1_fwd, s2_fwd;
  cache_word_t s1_fwd_word, s2_fwd_word;

  // read bank, aligned with the returning data.
  bank_t rd_bank_q1, rd_bank_q2;

  cache_word_t old_word;
  tag_t        old_tag;
  logic        old_vld;
  bank_t       old_bank;
  wr_disp_e    disp;
  logic        evict;
  logic        clear;
  cache_word_t res_word;

  // **************************************
  // request issue
  // **************************************

  assign pread    = read;
  assign prd_bank = rd_bank;
  assign prd_row  = rd_row;
  assign sread1   = read;
  assign srd_row1 = rd_row;
  // lookup of the row the write will land on.
  assign sread2   = write;
  assign srd_row2 = wr_row;

  // **************************************
  // write resolution
  // **************************************

  assign old_word = s2_fwd ? s2_fwd_word : {stag2, sdout2};
  assign old_tag  = old_word[CWORD_W-1 -: TAG_W];
  assign old_vld  = old_tag[TAG_W-1];
  assign old_bank = old_tag[BANK_W-1:0];

  always_comb begin
    if (!(read && rd_bank == s2_bank)) begin
      disp = WR_BANK;
    end else if (old_vld && old_bank == s2_bank) begin
      disp = WR_OVERWRITE;
    end else begin
      disp = WR_PARK;
    end
  end

  assign evict = s2_vld && disp == WR_PARK && old_vld;
  assign clear = s2_vld && disp == WR_BANK && old_vld && old_bank == s2_bank;

  // bank port carries either the write itself or the evicted entry.
  assign pwrite   = (s2_vld && disp == WR_BANK) || evict;
  assign pwr_bank = evict ? old_bank : s2_bank;
  assign pwr_row  = s2_row;
  assign pdin     = evict ? old_word[DATA_W-1:0] : s2_data;

  assign swrite  = s2_vld && (disp != WR_BANK || clear);
  assign swr_row = s2_row;
  assign stag    = {disp != WR_BANK, s2_bank};
  assign sdin    = s2_data;

  // cache row contents once this write has resolved.
  assign res_word = swrite ? {stag, sdin} : old_word;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      s1_fwd <= 1'b0;
      s2_fwd <= 1'b0;
    end else begin
      s1_vld <= write;
      s2_vld <= s1_vld;
      s1_fwd <= s2_vld && s2_row == wr_row;
      s2_fwd <= (s2_vld && s2_row == s1_row) || s1_fwd;
    end
  end

  // the younger in-flight write wins when both match the row.
  always_ff @(posedge clk) begin
    s1_bank     <= wr_bank;
    s1_row      <= wr_row;
    s1_data     <= wr_data;
    s1_fwd_word <= res_word;
    s2_bank     <= s1_bank;
    s2_row      <= s1_row;
    s2_data     <= s1_data;
    s2_fwd_word <= (s2_vld && s2_row == s1_row) ? res_word : s1_fwd_word;
    rd_bank_q1  <= rd_bank;
    rd_bank_q2  <= rd_bank_q1;
  end

  // **************************************
  // read select
  // **************************************

  assign rd_data = (stag1[TAG_W-1] && stag1[BANK_W-1:0] == rd_bank_q2) ? sdout1 : pdout;

  a_evict_free_bank: assert property (
    @(posedge clk) disable iff (!rst_n) evict |-> !(read && old_bank == rd_bank)
  ) else $error("eviction to bank %0d collides with the read", old_bank);

endmodule

//--- design/mem_1r1w_top.sv
module mem_1r1w_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                write,
  input  logic                read,
  input  mem_cfg_pkg::bank_t  wr_bank,
  input  mem_cfg_pkg::bank_t  rd_bank,
  input  mem_cfg_pkg::row_t   wr_row,
  input  mem_cfg_pkg::row_t   rd_row,
  input  mem_cfg_pkg::data_t  wr_data,
  output mem_cfg_pkg::data_t  rd_data
);

  import mem_cfg_pkg::*;
  import mem_ops_pkg::*;

  // controller to mux, flat strobes and addresses.
  logic  pwrite, pread, swrite, sread1, sread2;
  bank_t pwr_bank, prd_bank;
  row_t  pwr_row, prd_row, swr_row, srd_row1, srd_row2;
  data_t pdin, sdin, pdout, sdout1, sdout2;
  tag_t  stag, stag1, stag2;

  bank_port_if  bank_bus  (.clk(clk));
  cache_port_if cache_bus (.clk(clk));

  conflict_ctrl u_ctrl (.*);

  bank_mux u_mux (
    .*,
    .bank  (bank_bus),
    .cache (cache_bus)
  );

  bank_array u_banks (
    .clk (clk),
    .bus (bank_bus)
  );

  cache_sram u_cache (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (cache_bus)
  );

endmodule

//--- design/mem_cfg_pkg.sv
package mem_cfg_pkg;

  // **************************************
  // word and array geometry
  // **************************************

  // one memory word.
  localparam int DATA_W = 32;

  // banks and the index that picks one.
  localparam int NUM_BANKS = 8;
  localparam int BANK_W = 3;

  // rows per bank; the cache has the same row count.
  localparam int NUM_ROWS = 64;
  localparam int ROW_W = 6;

  // read latency of the banks and of the cache, in clock edges.
  localparam int RD_LAT = 2;

  // **************************************
  // vector types
  // **************************************

  typedef logic [DATA_W-1:0] data_t;
  typedef logic [BANK_W-1:0] bank_t;
  typedef logic [ROW_W-1:0]  row_t;

endpackage

//--- design/mem_ops_pkg.sv
package mem_ops_pkg;

  import mem_cfg_pkg::*;

  // tag is a valid bit on top of the owning bank index.
  localparam int TAG_W = BANK_W + 1;

  // one cache row, tag above data.
  localparam int CWORD_W = TAG_W + DATA_W;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [CWORD_W-1:0] cache_word_t;

  // how a delayed write is resolved against the read of its cycle.
  typedef enum logic [1:0] {
    WR_BANK,
    WR_PARK,
    WR_OVERWRITE
  } wr_disp_e;

endpackage

//--- dv/tb_mem_1r1w.sv
module tb_mem_1r1w;

  timeunit 1ns;
  timeprecision 1ps;

  import mem_cfg_pkg::*;

  localparam int ADDR_W   = BANK_W + ROW_W;
  localparam int NUM_ADDR = NUM_BANKS * NUM_ROWS;
  localparam int RAND_CYC = 150;
  // fill and readback take 1024 cycles; directed, random and drain about 180.
  localparam int MAX_CYC  = 1500;

  logic  clk;
  logic  rst_n;
  logic  write;
  logic  read;
  bank_t wr_bank;
  bank_t rd_bank;
  row_t  wr_row;
  row_t  rd_row;
  data_t wr_data;
  data_t rd_data;

  logic [31:0] seed;
  int          cycles = 0;

  // reference model of the whole address space.
  data_t model     [NUM_ADDR];
  logic  model_vld [NUM_ADDR];

  // writes on their way to becoming visible.
  logic [2:0]        wq_vld;
  logic [ADDR_W-1:0] wq_addr [3];
  data_t             wq_data [3];

  // expected read data, aligned with rd_data.
  logic [1:0] chk_q;
  data_t      exp_q    [2];
  bank_t      chk_bank [2];
  row_t       chk_row  [2];

  mem_1r1w_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .write   (write),
    .read    (read),
    .wr_bank (wr_bank),
    .rd_bank (rd_bank),
    .wr_row  (wr_row),
    .rd_row  (rd_row),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ****************************************
  // helpers
  // ****************************************

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t rand_word();
    seed = next_rand(seed);
    return seed;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic drive_cycle(input logic wr_en, input bank_t wb, input row_t wrow,
                             input data_t wd, input logic rd_en, input bank_t rb,
                             input row_t rrow);
    @(negedge clk);
    write   = wr_en;
    wr_bank = wb;
    wr_row  = wrow;
    wr_data = wd;
    read    = rd_en;
    rd_bank = rb;
    rd_row  = rrow;
  endtask

  task automatic read_addr(input bank_t rb, input row_t rrow);
    drive_cycle(1'b0, '0, '0, '0, 1'b1, rb, rrow);
  endtask

  // the write resolves against the read two cycles later, so the read is held three cycles.
  task automatic write_with_reads(input bank_t wb, input row_t wrow, input data_t wd,
                                  input bank_t rb, input row_t rrow);
    drive_cycle(1'b1, wb, wrow, wd, 1'b1, rb, rrow);
    read_addr(rb, rrow);
    read_addr(rb, rrow);
  endtask

  // ****************************************
  // reference model and checks
  // ****************************************

  always @(posedge clk) begin : model_update
    logic [ADDR_W-1:0] ra;
    ra = {rd_bank, rd_row};
    if (!rst_n) begin
      wq_vld <= '0;
      chk_q  <= '0;
      for (int i = 0; i < NUM_ADDR; i++) begin
        model_vld[i] = 1'b0;
      end
    end else begin
      // write sampled three edges ago is visible to this read.
      if (wq_vld[2]) begin
        model[wq_addr[2]]     = wq_data[2];
        model_vld[wq_addr[2]] = 1'b1;
      end
      wq_vld     <= {wq_vld[1:0], write};
      wq_addr[0] <= {wr_bank, wr_row};
      wq_addr[1] <= wq_addr[0];
      wq_addr[2] <= wq_addr[1];
      wq_data[0] <= wr_data;
      wq_data[1] <= wq_data[0];
      wq_data[2] <= wq_data[1];
      chk_q       <= {chk_q[0], read && model_vld[ra]};
      exp_q[0]    <= model[ra];
      exp_q[1]    <= exp_q[0];
      chk_bank[0] <= rd_bank;
      chk_bank[1] <= chk_bank[0];
      chk_row[0]  <= rd_row;
      chk_row[1]  <= chk_row[0];
    end
  end

  a_rd_data: assert property (
    @(posedge clk) disable iff (!rst_n) chk_q[1] |-> (rd_data == exp_q[1])
  ) else begin
    abort_run($sformatf("ERR %0t: read of bank %0d row %0d returned %h, expected %h",
                        $time, $sampled(chk_bank[1]), $sampled(chk_row[1]),
                        $sampled(rd_data), $sampled(exp_q[1])));
  end

  always @(posedge clk) begin
    if (cycles >= MAX_CYC) begin
      abort_run($sformatf("timeout: test still running after %0d cycles", MAX_CYC));
    end else begin
      cycles <= cycles + 1;
    end
  end

  // ****************************************
  // stimulus
  // ****************************************

  initial begin
    logic [31:0] x;
    bank_t       rb;
    bank_t       wb;
    row_t        rr;
    row_t        wr;
    rst_n   = 1'b0;
    write   = 1'b0;
    read    = 1'b0;
    wr_bank = '0;
    rd_bank = '0;
    wr_row  = '0;
    rd_row  = '0;
    wr_data = '0;
    seed    = 32'ha424afbf;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // fill every address, then read it all back.
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        drive_cycle(1'b1, bank_t'(b), row_t'(r), rand_word(), 1'b0, '0, '0);
      end
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int r = 0; r < NUM_ROWS; r++) begin
        read_addr(bank_t'(b), row_t'(r));
      end
    end

    // write and read in different banks.
    write_with_reads(3'd1, 6'd5, rand_word(), 3'd2, 6'd5);
    read_addr(3'd1, 6'd5);

    // same bank, other row, so the write is parked.
    write_with_reads(3'd3, 6'd10, rand_word(), 3'd3, 6'd11);
    read_addr(3'd3, 6'd10);
    read_addr(3'd3, 6'd11);

    // second park on row 20 evicts the first.
    write_with_reads(3'd4, 6'd20, rand_word(), 3'd4, 6'd21);
    write_with_reads(3'd5, 6'd20, rand_word(), 3'd5, 6'd21);
    read_addr(3'd4, 6'd20);
    read_addr(3'd5, 6'd20);

    // overwrite the parked entry, then a bank write clears its tag.
    write_with_reads(3'd6, 6'd30, rand_word(), 3'd6, 6'd30);
    write_with_reads(3'd6, 6'd30, rand_word(), 3'd6, 6'd31);
    read_addr(3'd6, 6'd30);
    write_with_reads(3'd6, 6'd30, rand_word(), 3'd0, 6'd30);
    read_addr(3'd6, 6'd30);

    // random mix over few banks and rows to force collisions.
    for (int i = 0; i < RAND_CYC; i++) begin
      x  = rand_word();
      rb = {1'b0, x[1:0]};
      wb = x[2] ? rb : {1'b0, x[9:8]};
      rr = {4'd0, x[5:4]};
      wr = {4'd0, x[13:12]};
      drive_cycle(x[16] | x[17], wb, wr, rand_word(), x[18] | x[19], rb, rr);
    end

    drive_cycle(1'b0, '0, '0, '0, 1'b0, '0, '0);
    repeat (4) @(negedge clk);
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- run.sh
#!/bin/sh
# build with Verilator, run, and judge the run from sim.log.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_mem_1r1w \
  -f verilog.f -o tb_mem_1r1w || { echo "build failed"; exit 1; }

./obj_dir/tb_mem_1r1w > sim.log 2>&1

grep -q "Result: FAILED" sim.log && { echo "test failed, see sim.log"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "test did not complete, see sim.log"; exit 1; }
echo "test passed"

//--- verilog.f
design/mem_cfg_pkg.sv
design/mem_ops_pkg.sv
design/bank_port_if.sv
design/cache_port_if.sv
design/bank_array.sv
design/cache_sram.sv
design/bank_mux.sv
design/conflict_ctrl.sv
design/mem_1r1w_top.sv
dv/tb_mem_1r1w.sv
